/* logic/cluster_pkg.sv */
`default_nettype none

package cluster_pkg;

  //////////////////////////////////////////////////////////////////////
  // Cluster geometry
  //////////////////////////////////////////////////////////////////////
  localparam int NUM_CORES     = 4;
  localparam int CORE_ID_WIDTH = 2;
  localparam int DESC_WIDTH    = 64;
  localparam int ADDR_WIDTH    = 32;

  // Packet buffer region in DRAM, 2 KB per slot
  localparam logic [ADDR_WIDTH-1:0] DRAM_BASE  = 32'h0100_0000;
  localparam int                    SLOT_SHIFT = 11;

  // Descriptor kinds
  localparam logic [3:0] KIND_PKT  = 4'h1;
  localparam logic [3:0] KIND_CTRL = 4'h2;

  //////////////////////////////////////////////////////////////////////
  // Descriptor views
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [3:0]  kind;
    logic [3:0]  port;
    logic [7:0]  slot;
    logic [15:0] len;
    logic [31:0] tag;
  } pkt_desc_t;

  // Writes one routing table entry on every core
  typedef struct packed {
    logic [3:0]  kind;
    logic [3:0]  entry;
    logic [3:0]  new_port;
    logic [51:0] unused;
  } ctrl_desc_t;

  // Kind sits in the top nibble of both views
  typedef union packed {
    pkt_desc_t  pkt;
    ctrl_desc_t ctrl;
  } desc_u;

endpackage

`default_nettype wire

/* logic/desc_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One descriptor channel with its DRAM address
interface desc_if
  import cluster_pkg::*;
();

  desc_u                 desc;
  logic [ADDR_WIDTH-1:0] dram_addr;
  logic                  valid;
  logic                  ready;

  modport source (
    output desc, dram_addr, valid,
    input  ready
  );

  modport sink (
    input  desc, dram_addr, valid,
    output ready
  );

endinterface

`default_nettype wire

/* logic/pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter int DATA_WIDTH = 96
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  [DATA_WIDTH-1:0] s_data,
  input  wire                   s_valid,
  output logic                  s_ready,
  output logic [DATA_WIDTH-1:0] m_data,
  output logic                  m_valid,
  input  wire                   m_ready
);

  logic [DATA_WIDTH-1:0] skid_data;
  logic                  skid_valid;
  logic                  skid_valid_next;
  logic                  main_load;
  logic                  s_fire;

  assign s_fire = s_valid && s_ready;

  // Main register is empty or being drained
  assign main_load = !m_valid || m_ready;

  always_comb begin
    skid_valid_next = skid_valid;
    if (skid_valid && main_load) begin
      skid_valid_next = 1'b0;
    end else if (s_fire && !main_load) begin
      skid_valid_next = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      s_ready    <= 1'b0;
    end else begin
      skid_valid <= skid_valid_next;
      s_ready    <= !skid_valid_next;
      if (main_load) begin
        m_valid <= skid_valid || s_fire;
      end
    end
  end

  // Skid entry drains first so order is kept
  always_ff @(posedge clk) begin
    if (main_load) begin
      m_data <= skid_valid ? skid_data : s_data;
    end
    if (s_fire && !main_load) begin
      skid_data <= s_data;
    end
  end

endmodule

`default_nettype wire

/* logic/core_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module core_engine
  import cluster_pkg::*;
(
  input  wire    clk,
  input  wire    rst,
  desc_if.sink   in_ch,
  desc_if.source out_ch
);

  logic [3:0]            route_tbl [16];
  logic                  in_fire;
  logic                  is_pkt;
  logic                  is_ctrl;
  desc_u                 pkt_out;

  desc_u                 out_desc;
  logic [ADDR_WIDTH-1:0] out_addr;
  logic                  out_valid;

  assign is_pkt  = (in_ch.desc.pkt.kind == KIND_PKT);
  assign is_ctrl = (in_ch.desc.ctrl.kind == KIND_CTRL);

  assign in_ch.ready = !out_valid || out_ch.ready;
  assign in_fire     = in_ch.valid && in_ch.ready;

  //////////////////////////////////////////////////////////////////////
  // Routing table
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        route_tbl[i] <= 4'(i);
      end
    end else if (in_fire && is_ctrl) begin
      route_tbl[in_ch.desc.ctrl.entry] <= in_ch.desc.ctrl.new_port;
    end
  end

  // Only the port field changes
  always_comb begin
    pkt_out          = in_ch.desc;
    pkt_out.pkt.port = route_tbl[in_ch.desc.pkt.port];
  end

  //////////////////////////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (in_fire && is_pkt) begin
      out_valid <= 1'b1;
    end else if (out_ch.ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire && is_pkt) begin
      out_desc <= pkt_out;
      out_addr <= in_ch.dram_addr;
    end
  end

  assign out_ch.desc      = out_desc;
  assign out_ch.dram_addr = out_addr;
  assign out_ch.valid     = out_valid;

endmodule

`default_nettype wire

/* logic/core_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module core_wrapper
  import cluster_pkg::*;
(
  input  wire    clk,
  input  wire    rst,
  desc_if.sink   in_ch,
  desc_if.source out_ch
);

  logic                             rst_r;
  logic [DESC_WIDTH+ADDR_WIDTH-1:0] in_data_r;
  logic [DESC_WIDTH+ADDR_WIDTH-1:0] out_data_r;

  desc_if eng_in ();
  desc_if eng_out ();

  // Local copy of reset for timing
  always_ff @(posedge clk) begin
    rst_r <= rst;
  end

  //////////////////////////////////////////////////////////////////////
  // Incoming descriptor register
  //////////////////////////////////////////////////////////////////////
  pipe_reg #(
    .DATA_WIDTH(DESC_WIDTH + ADDR_WIDTH)
  ) in_desc_reg (
    .clk    (clk),
    .rst    (rst_r),
    .s_data ({in_ch.desc, in_ch.dram_addr}),
    .s_valid(in_ch.valid),
    .s_ready(in_ch.ready),
    .m_data (in_data_r),
    .m_valid(eng_in.valid),
    .m_ready(eng_in.ready)
  );

  assign eng_in.desc      = in_data_r[DESC_WIDTH+ADDR_WIDTH-1:ADDR_WIDTH];
  assign eng_in.dram_addr = in_data_r[ADDR_WIDTH-1:0];

  core_engine core_inst (
    .clk   (clk),
    .rst   (rst_r),
    .in_ch (eng_in.sink),
    .out_ch(eng_out.source)
  );

  //////////////////////////////////////////////////////////////////////
  // Outgoing descriptor register
  //////////////////////////////////////////////////////////////////////
  pipe_reg #(
    .DATA_WIDTH(DESC_WIDTH + ADDR_WIDTH)
  ) out_desc_reg (
    .clk    (clk),
    .rst    (rst_r),
    .s_data ({eng_out.desc, eng_out.dram_addr}),
    .s_valid(eng_out.valid),
    .s_ready(eng_out.ready),
    .m_data (out_data_r),
    .m_valid(out_ch.valid),
    .m_ready(out_ch.ready)
  );

  assign out_ch.desc      = out_data_r[DESC_WIDTH+ADDR_WIDTH-1:ADDR_WIDTH];
  assign out_ch.dram_addr = out_data_r[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

/* logic/desc_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_dispatch
  import cluster_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire [DESC_WIDTH-1:0] in_desc,
  input  wire                  in_desc_valid,
  output logic                 in_desc_ready,
  desc_if.source               core_ch [NUM_CORES]
);

  desc_u                    in_d;
  logic                     is_pkt;
  logic                     is_ctrl;
  logic                     in_fire;
  logic                     run;
  logic [ADDR_WIDTH-1:0]    pkt_addr;

  // One output slot per core
  desc_u                    slot_desc [NUM_CORES];
  logic [ADDR_WIDTH-1:0]    slot_addr [NUM_CORES];
  logic [NUM_CORES-1:0]     slot_valid;
  logic [NUM_CORES-1:0]     slot_free;
  logic [NUM_CORES-1:0]     core_ready;

  logic [CORE_ID_WIDTH-1:0] rr_ptr;
  logic [CORE_ID_WIDTH-1:0] pick;
  logic [CORE_ID_WIDTH-1:0] idx;
  logic                     pick_found;

  assign in_d     = in_desc;
  assign is_pkt   = (in_d.pkt.kind == KIND_PKT);
  assign is_ctrl  = (in_d.ctrl.kind == KIND_CTRL);
  assign in_fire  = in_desc_valid && in_desc_ready;
  assign pkt_addr = DRAM_BASE + (ADDR_WIDTH'(in_d.pkt.slot) << SLOT_SHIFT);

  assign slot_free = ~slot_valid | core_ready;

  // First free core from the round-robin pointer
  always_comb begin
    pick_found = 1'b0;
    pick       = rr_ptr;
    for (int i = 0; i < NUM_CORES; i++) begin
      idx = rr_ptr + CORE_ID_WIDTH'(i);
      if (!pick_found && slot_free[idx]) begin
        pick_found = 1'b1;
        pick       = idx;
      end
    end
  end

  // Broadcast waits for every slot to be empty
  always_comb begin
    if (!run) begin
      in_desc_ready = 1'b0;
    end else if (is_pkt) begin
      in_desc_ready = pick_found;
    end else if (is_ctrl) begin
      in_desc_ready = (slot_valid == '0);
    end else begin
      in_desc_ready = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run        <= 1'b0;
      rr_ptr     <= '0;
      slot_valid <= '0;
    end else begin
      run        <= 1'b1;
      slot_valid <= slot_valid & ~core_ready;
      if (in_fire && is_pkt) begin
        slot_valid[pick] <= 1'b1;
        rr_ptr           <= pick + 1'b1;
      end
      // Each core clears its own bit as it takes the broadcast
      if (in_fire && is_ctrl) begin
        slot_valid <= '1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < NUM_CORES; c++) begin
      if (in_fire && is_ctrl) begin
        slot_desc[c] <= in_d;
        slot_addr[c] <= '0;
      end else if (in_fire && is_pkt && pick == CORE_ID_WIDTH'(c)) begin
        slot_desc[c] <= in_d;
        slot_addr[c] <= pkt_addr;
      end
    end
  end

  for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
    assign core_ch[g].desc      = slot_desc[g];
    assign core_ch[g].dram_addr = slot_addr[g];
    assign core_ch[g].valid     = slot_valid[g];
    assign core_ready[g]        = core_ch[g].ready;
  end

endmodule

`default_nettype wire

/* logic/desc_collect.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_collect
  import cluster_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,
  desc_if.sink                     core_ch [NUM_CORES],
  output logic [DESC_WIDTH-1:0]    out_desc,
  output logic [ADDR_WIDTH-1:0]    out_dram_addr,
  output logic [CORE_ID_WIDTH-1:0] out_core,
  output logic                     out_desc_valid,
  input  wire                      out_desc_ready
);

  desc_u                    core_desc [NUM_CORES];
  logic [ADDR_WIDTH-1:0]    core_addr [NUM_CORES];
  logic [NUM_CORES-1:0]     core_valid;
  logic [NUM_CORES-1:0]     grant_vec;

  logic [CORE_ID_WIDTH-1:0] rr_ptr;
  logic [CORE_ID_WIDTH-1:0] grant;
  logic [CORE_ID_WIDTH-1:0] idx;
  logic                     grant_found;
  logic                     load_en;

  for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
    assign core_desc[g]     = core_ch[g].desc;
    assign core_addr[g]     = core_ch[g].dram_addr;
    assign core_valid[g]    = core_ch[g].valid;
    assign core_ch[g].ready = grant_vec[g];
  end

  // Output stage is empty or being taken
  assign load_en = !out_desc_valid || out_desc_ready;

  //////////////////////////////////////////////////////////////////////
  // Round-robin arbiter
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    grant_found = 1'b0;
    grant       = rr_ptr;
    for (int i = 0; i < NUM_CORES; i++) begin
      idx = rr_ptr + CORE_ID_WIDTH'(i);
      if (!grant_found && core_valid[idx]) begin
        grant_found = 1'b1;
        grant       = idx;
      end
    end
    grant_vec = '0;
    if (load_en && grant_found) begin
      grant_vec[grant] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_desc_valid <= 1'b0;
      rr_ptr         <= '0;
    end else if (load_en) begin
      out_desc_valid <= grant_found;
      if (grant_found) begin
        rr_ptr <= grant + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_en && grant_found) begin
      out_desc      <= core_desc[grant];
      out_dram_addr <= core_addr[grant];
      out_core      <= grant;
    end
  end

endmodule

`default_nettype wire

/* logic/cluster_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cluster_top
  import cluster_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,

  input  wire [DESC_WIDTH-1:0]    in_desc,
  input  wire                     in_desc_valid,
  output wire                     in_desc_ready,

  output wire [DESC_WIDTH-1:0]    out_desc,
  output wire [ADDR_WIDTH-1:0]    out_dram_addr,
  output wire [CORE_ID_WIDTH-1:0] out_core,
  output wire                     out_desc_valid,
  input  wire                     out_desc_ready
);

  desc_if disp_to_core [NUM_CORES] ();
  desc_if core_to_coll [NUM_CORES] ();

  desc_dispatch dispatch_inst (
    .clk          (clk),
    .rst          (rst),
    .in_desc      (in_desc),
    .in_desc_valid(in_desc_valid),
    .in_desc_ready(in_desc_ready),
    .core_ch      (disp_to_core)
  );

  //////////////////////////////////////////////////////////////////////
  // Core wrappers
  //////////////////////////////////////////////////////////////////////
  for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
    core_wrapper wrapper_inst (
      .clk   (clk),
      .rst   (rst),
      .in_ch (disp_to_core[g]),
      .out_ch(core_to_coll[g])
    );
  end

  desc_collect collect_inst (
    .clk           (clk),
    .rst           (rst),
    .core_ch       (core_to_coll),
    .out_desc      (out_desc),
    .out_dram_addr (out_dram_addr),
    .out_core      (out_core),
    .out_desc_valid(out_desc_valid),
    .out_desc_ready(out_desc_ready)
  );

endmodule

`default_nettype wire

/* bench/tb_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cluster
  import cluster_pkg::*;
();

  localparam int MAX_ENTRIES = 64;
  localparam int WAIT_LIMIT  = 2000;

  logic                     clk;
  logic                     rst;
  logic [DESC_WIDTH-1:0]    in_desc;
  logic                     in_desc_valid;
  wire                      in_desc_ready;
  wire  [DESC_WIDTH-1:0]    out_desc;
  wire  [ADDR_WIDTH-1:0]    out_dram_addr;
  wire  [CORE_ID_WIDTH-1:0] out_core;
  wire                      out_desc_valid;
  logic                     out_desc_ready;

  // Stimulus table
  logic [DESC_WIDTH-1:0] tbl_desc [MAX_ENTRIES];
  string                 tbl_name [MAX_ENTRIES];
  bit                    tbl_bp   [MAX_ENTRIES];
  int                    tbl_len;

  // Scoreboard indexed by the low tag byte
  logic [DESC_WIDTH-1:0] exp_desc [256];
  logic [ADDR_WIDTH-1:0] exp_addr [256];
  string                 exp_name [256];
  bit                    pending  [256];
  int                    pending_cnt;

  logic [3:0]            route_model [16];
  logic [NUM_CORES-1:0]  core_seen;
  bit                    bp_on;

  cluster_top DUT (
    .clk           (clk),
    .rst           (rst),
    .in_desc       (in_desc),
    .in_desc_valid (in_desc_valid),
    .in_desc_ready (in_desc_ready),
    .out_desc      (out_desc),
    .out_dram_addr (out_dram_addr),
    .out_core      (out_core),
    .out_desc_valid(out_desc_valid),
    .out_desc_ready(out_desc_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      stop_with_fail($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////////////////////////
  function automatic void add_entry(input string name, input logic [63:0] d, input bit bp);
    tbl_desc[tbl_len] = d;
    tbl_name[tbl_len] = name;
    tbl_bp[tbl_len]   = bp;
    tbl_len++;
  endfunction

  function automatic void add_pkt(input string name, input logic [3:0] port,
                                  input logic [7:0] slot, input logic [15:0] len, input bit bp);
    pkt_desc_t p;
    p.kind = KIND_PKT;
    p.port = port;
    p.slot = slot;
    p.len  = len;
    p.tag  = 32'hC0DE_0000 | 32'(tbl_len);
    add_entry(name, p, bp);
  endfunction

  function automatic void add_ctrl(input string name, input logic [3:0] entry,
                                   input logic [3:0] new_port, input bit bp);
    ctrl_desc_t c;
    c.kind     = KIND_CTRL;
    c.entry    = entry;
    c.new_port = new_port;
    c.unused   = '0;
    add_entry(name, c, bp);
  endfunction

  function automatic void build_table();
    for (int i = 0; i < 4; i++) begin
      add_pkt("identity", 4'(i * 5), 8'(i * 17), 16'(64 + i), 1'b0);
    end
    add_ctrl("ctrl write", 4'd3, 4'd9, 1'b0);
    for (int i = 0; i < 4; i++) begin
      add_pkt("remapped port", 4'd3, 8'(200 + i), 16'(1500 - i), 1'b0);
    end
    add_pkt("other port", 4'd5, 8'd42, 16'd128, 1'b0);
    // Back to back over all cores
    for (int i = 0; i < 12; i++) begin
      add_pkt("spread", 4'($urandom), 8'($urandom), 16'($urandom), 1'b0);
    end
    add_entry("unknown kind", {4'h7, 28'h0, 32'hC0DE_0000 | 32'(tbl_len)}, 1'b0);
    add_pkt("after unknown", 4'd1, 8'd7, 16'd60, 1'b0);
    add_pkt("after unknown", 4'd3, 8'd8, 16'd61, 1'b0);
    add_ctrl("ctrl under stall", 4'd12, 4'd2, 1'b1);
    for (int i = 0; i < 16; i++) begin
      add_pkt("back-pressure", 4'($urandom), 8'($urandom), 16'($urandom), 1'b1);
    end
  endfunction

  // Reference routing and address rules
  function automatic void update_model(input desc_u d, input string name);
    desc_u e;
    int    idx;
    if (d.pkt.kind == KIND_PKT) begin
      e          = d;
      e.pkt.port = route_model[d.pkt.port];
      idx        = int'(d.pkt.tag[7:0]);
      exp_desc[idx] = e;
      exp_addr[idx] = DRAM_BASE + 32'(d.pkt.slot) * 32'd2048;
      exp_name[idx] = name;
      pending[idx]  = 1'b1;
      pending_cnt++;
    end else if (d.ctrl.kind == KIND_CTRL) begin
      route_model[d.ctrl.entry] = d.ctrl.new_port;
    end
  endfunction

  task automatic apply_entry(input int i);
    int n;
    n = 0;
    bp_on         <= tbl_bp[i];
    in_desc       <= tbl_desc[i];
    in_desc_valid <= 1'b1;
    @(negedge clk);
    while (!in_desc_ready) begin
      n++;
      if (n > WAIT_LIMIT) begin
        stop_with_fail($sformatf("Timed out waiting for in_desc_ready on %s", tbl_name[i]));
      end else begin
        @(negedge clk);
      end
    end
    @(posedge clk);
    update_model(tbl_desc[i], tbl_name[i]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (bp_on) begin
      out_desc_ready <= 1'($urandom % 2);
    end else begin
      out_desc_ready <= 1'b1;
    end
  end

  // Handshake values are stable at the falling edge
  always @(negedge clk) begin
    int idx;
    if (!rst && out_desc_valid && out_desc_ready) begin
      idx = int'(out_desc[7:0]);
      if (!pending[idx]) begin
        stop_with_fail($sformatf("Output with tag %h was not expected or came out twice",
                                 out_desc[31:0]));
      end else begin
        check({exp_name[idx], " desc"}, exp_desc[idx], out_desc);
        check({exp_name[idx], " dram_addr"}, 64'(exp_addr[idx]), 64'(out_dram_addr));
        pending[idx] = 1'b0;
        pending_cnt--;
        core_seen[out_core] = 1'b1;
      end
    end
  end

  initial begin
    int n;
    void'($urandom(64));
    rst            = 1'b1;
    in_desc        = '0;
    in_desc_valid  = 1'b0;
    out_desc_ready = 1'b0;
    bp_on          = 1'b0;
    pending_cnt    = 0;
    core_seen      = '0;
    tbl_len        = 0;
    for (int i = 0; i < 256; i++) begin
      pending[i] = 1'b0;
    end
    for (int i = 0; i < 16; i++) begin
      route_model[i] = 4'(i);
    end
    build_table();

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < tbl_len; i++) begin
      apply_entry(i);
    end
    in_desc_valid <= 1'b0;

    n = 0;
    while (pending_cnt != 0) begin
      n++;
      if (n > WAIT_LIMIT) begin
        stop_with_fail($sformatf("Timed out waiting for %0d outstanding packets", pending_cnt));
      end else begin
        @(posedge clk);
      end
    end
    bp_on <= 1'b0;

    // A dropped descriptor must not show up late
    repeat (20) @(posedge clk);
    check("core coverage", 64'({NUM_CORES{1'b1}}), 64'(core_seen));

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
logic/cluster_pkg.sv
logic/desc_if.sv
logic/pipe_reg.sv
logic/core_engine.sv
logic/core_wrapper.sv
logic/desc_dispatch.sv
logic/desc_collect.sv
logic/cluster_top.sv
bench/tb_cluster.sv
